/* cps15_snd.f */
+incdir+tests
hw/cps15_snd_pkg.sv
hw/cps15_main_if.sv
hw/cps15_cmd_fifo.sv
hw/cps15_qsnd_seq.sv
hw/cps15_snd_game.sv
tests/cps15_snd_tb.sv

/* Bender.yml */
package:
  name: cps15_snd

sources:
  - files:
      - hw/cps15_snd_pkg.sv
      - hw/cps15_main_if.sv
      - hw/cps15_cmd_fifo.sv
      - hw/cps15_qsnd_seq.sv
      - hw/cps15_snd_game.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cps15_snd_tb.sv

/* tests/cps15_snd_model.svh */
`ifndef CPS15_SND_MODEL_SVH
`define CPS15_SND_MODEL_SVH

// Mirror of the command FIFO contents and the sequencer state
logic [CMD_W-1:0]        model_q[$];
logic [VOL_W-1:0]        m_vol_l = '0;
logic [VOL_W-1:0]        m_vol_r = '0;
logic signed [ARG_W-1:0] m_level = '0;

int err_sample;
int err_rdata;
int err_slverr;
int err_count;
int err_other;

// Output value for one channel, level times volume
function automatic snd_sample_t model_mix(input logic [VOL_W-1:0] vol);
    int prod;
    prod = int'(m_level) * int'(vol);
    return snd_sample_t'(prod);
endfunction

// Opcode rules, one command at a time
function automatic void model_apply(input logic [CMD_W-1:0] cmd);
    logic [ARG_W-1:0] arg;
    arg = cmd[ARG_W-1:0];
    case (snd_op_e'(cmd[CMD_W-1:ARG_W]))
        OP_VOL_L: m_vol_l = arg[VOL_W-1:0];
        OP_VOL_R: m_vol_r = arg[VOL_W-1:0];
        OP_PLAY:  m_level = $signed(arg);
        OP_MUTE: begin
            m_vol_l = '0;
            m_vol_r = '0;
        end
        default: ;
    endcase
endfunction

// STATUS word as the register map defines it
function automatic logic [APB_DW-1:0] model_status();
    logic [APB_DW-1:0] word;
    word      = '0;
    word[7:0] = 8'(model_q.size());
    word[8]   = (model_q.size() == 0);
    word[9]   = (model_q.size() == FIFO_DEPTH);
    return word;
endfunction

task automatic compare_sample(input string name, input snd_sample_t exp, input snd_sample_t act);
    if (exp !== act) begin
        err_sample++;
        $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic compare_rdata(input string name, input logic [APB_DW-1:0] exp,
                             input logic [APB_DW-1:0] act);
    if (exp !== act) begin
        err_rdata++;
        $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
endtask

task automatic compare_slverr(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        err_slverr++;
        $display("MISMATCH %s: expected pslverr %0b, actual %0b", name, exp, act);
    end
endtask

task automatic compare_count(input string name, input int exp, input int act);
    if (exp != act) begin
        err_count++;
        $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

`endif

/* tests/cps15_snd_tb.sv */
`timescale 1ns/1ps

module cps15_snd_tb;

    import cps15_snd_pkg::*;

    localparam int  FIFO_DEPTH  = 8;
    localparam int  SAMPLE_DIV  = 16;
    localparam int  NUM_BATCHES = 40;
    localparam real CLK_NS      = 8.0;
    // Nominal span per batch four times over
    localparam real WATCHDOG_NS = 4.0 * NUM_BATCHES * (FIFO_DEPTH + 4) * SAMPLE_DIV * CLK_NS;

    logic              clk;
    logic              rst_n;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    snd_sample_t       snd_left;
    snd_sample_t       snd_right;
    logic              sample;

    `include "cps15_snd_model.svh"

    cps15_snd_game #(
        .FIFO_DEPTH ( FIFO_DEPTH ),
        .SAMPLE_DIV ( SAMPLE_DIV )
    ) cps15_snd_game_i (.*);

    always #(CLK_NS / 2.0) clk = ~clk;

    // Setup then access cycle with results taken at the falling edge
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        if (!pready) begin
            err_other++;
            $display("ERROR: pready low in an APB access cycle");
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_strobe();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!sample && n <= 2 * SAMPLE_DIV);
        if (!sample) begin
            err_other++;
            $display("ERROR: no sample strobe within %0d cycles", 2 * SAMPLE_DIV);
        end
    endtask

    task automatic check_outputs(input string name);
        compare_sample({name, " left"}, model_mix(m_vol_l), snd_left);
        compare_sample({name, " right"}, model_mix(m_vol_r), snd_right);
    endtask

    function automatic logic [APB_AW-1:0] unmapped_addr();
        logic [APB_AW-1:0] a;
        do begin
            a = APB_AW'($urandom);
        end while (a inside {REG_CMD, REG_CTRL, REG_STATUS});
        return a;
    endfunction

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run timed out after %0t without finishing the tests", $time);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [APB_DW-1:0] rdata;
        logic              err;
        logic [CMD_W-1:0]  cmd;
        int                n;
        int                polls;
        int                gap;
        clk     = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(32'hbce1));
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state
        apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
        compare_rdata("reset status", model_status(), rdata);
        apb_xfer(1'b0, REG_CTRL, '0, rdata, err);
        compare_rdata("reset ctrl", '0, rdata);
        wait_strobe();
        compare_sample("reset left", 16'sd0, snd_left);
        compare_sample("reset right", 16'sd0, snd_right);

        // Strobe width and spacing
        repeat (4) begin
            wait_strobe();
            @(negedge clk);
            compare_count("strobe width", 0, int'(sample));
            gap = 1;
            while (!sample && gap < 2 * SAMPLE_DIV) begin
                @(negedge clk);
                gap++;
            end
            compare_count("strobe spacing", SAMPLE_DIV, gap);
        end

        for (int b = 0; b < NUM_BATCHES; b++) begin
            // Fill with run cleared so overflow writes get refused
            n = $urandom_range(FIFO_DEPTH + 3, 1);
            for (int i = 0; i < n; i++) begin
                cmd = {4'($urandom_range(4, 0)), 12'($urandom)};
                apb_xfer(1'b1, REG_CMD, APB_DW'(cmd), rdata, err);
                compare_slverr("fill write", model_q.size() >= FIFO_DEPTH, err);
                if (model_q.size() < FIFO_DEPTH) begin
                    model_q.push_back(cmd);
                end
            end
            apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
            compare_rdata("fill status", model_status(), rdata);

            // Error accesses
            apb_xfer(1'b1, unmapped_addr(), $urandom, rdata, err);
            compare_slverr("unmapped write", 1'b1, err);
            apb_xfer(1'b0, unmapped_addr(), '0, rdata, err);
            compare_slverr("unmapped read", 1'b1, err);
            apb_xfer(1'b1, REG_STATUS, $urandom, rdata, err);
            compare_slverr("status write", 1'b1, err);
            apb_xfer(1'b0, REG_CMD, '0, rdata, err);
            compare_rdata("cmd read", '0, rdata);
            apb_xfer(1'b0, REG_CTRL, '0, rdata, err);
            compare_rdata("ctrl after errors", '0, rdata);
            apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
            compare_rdata("status after errors", model_status(), rdata);

            // Nothing moves while run is low
            repeat (3) begin
                wait_strobe();
                check_outputs("gated");
            end
            apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
            compare_rdata("gated status", model_status(), rdata);

            // Drain
            apb_xfer(1'b1, REG_CTRL, 32'h1, rdata, err);
            compare_slverr("run set", 1'b0, err);
            apb_xfer(1'b0, REG_CTRL, '0, rdata, err);
            compare_rdata("ctrl run", 32'h1, rdata);
            polls = 0;
            do begin
                apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
                polls++;
            end while (!rdata[8] && polls < FIFO_DEPTH * SAMPLE_DIV);
            if (!rdata[8]) begin
                err_other++;
                $display("ERROR: command FIFO did not drain with run set");
            end
            while (model_q.size() > 0) begin
                model_apply(model_q.pop_front());
            end
            wait_strobe();
            check_outputs("drain");
            apb_xfer(1'b1, REG_CTRL, '0, rdata, err);
        end

        $display("Errors: sample=%0d rdata=%0d pslverr=%0d count=%0d other=%0d",
                 err_sample, err_rdata, err_slverr, err_count, err_other);
        if (err_sample + err_rdata + err_slverr + err_count + err_other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* hw/cps15_snd_game.sv */
`timescale 1ns/1ps

module cps15_snd_game #(
    parameter int FIFO_DEPTH = 8,
    parameter int SAMPLE_DIV = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // Main CPU register port (APB)
    input  logic [cps15_snd_pkg::APB_AW-1:0]  paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [cps15_snd_pkg::APB_DW-1:0]  pwdata,
    output logic [cps15_snd_pkg::APB_DW-1:0]  prdata,
    output logic                              pready,
    output logic                              pslverr,
    // Sound output
    output cps15_snd_pkg::snd_sample_t        snd_left,
    output cps15_snd_pkg::snd_sample_t        snd_right,
    output logic                              sample
);

    import cps15_snd_pkg::*;

    localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

    // Bridge to FIFO
    logic             push;
    logic [CMD_W-1:0] push_data;
    logic [LVL_W-1:0] level;
    logic             full;
    logic             empty;
    // FIFO to sequencer
    logic             pop;
    logic [CMD_W-1:0] pop_data;
    logic             run;

    cps15_main_if #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_main_if (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .paddr      ( paddr      ),
        .psel       ( psel       ),
        .penable    ( penable    ),
        .pwrite     ( pwrite     ),
        .pwdata     ( pwdata     ),
        .prdata     ( prdata     ),
        .pready     ( pready     ),
        .pslverr    ( pslverr    ),
        .level      ( level      ),
        .full       ( full       ),
        .empty      ( empty      ),
        .push       ( push       ),
        .push_data  ( push_data  ),
        .run        ( run        )
    );

    cps15_cmd_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH ),
        .CMD_W      ( CMD_W      )
    ) u_cmd_fifo (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .push       ( push       ),
        .push_data  ( push_data  ),
        .pop        ( pop        ),
        .pop_data   ( pop_data   ),
        .level      ( level      ),
        .full       ( full       ),
        .empty      ( empty      )
    );

    cps15_qsnd_seq #(
        .SAMPLE_DIV ( SAMPLE_DIV )
    ) u_qsnd_seq (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .run        ( run        ),
        .pop_data   ( pop_data   ),
        .empty      ( empty      ),
        .pop        ( pop        ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .sample     ( sample     )
    );

endmodule

/* hw/cps15_qsnd_seq.sv */
`timescale 1ns/1ps

module cps15_qsnd_seq #(
    parameter int SAMPLE_DIV = 16
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             run,
    // Command FIFO head
    input  logic [cps15_snd_pkg::CMD_W-1:0]  pop_data,
    input  logic                             empty,
    output logic                             pop,
    // Sound output
    output cps15_snd_pkg::snd_sample_t       snd_left,
    output cps15_snd_pkg::snd_sample_t       snd_right,
    output logic                             sample
);

    import cps15_snd_pkg::*;

    localparam int DIV_W = $clog2(SAMPLE_DIV);

    logic [DIV_W-1:0]        div_cnt;
    logic                    tick;

    snd_op_e                 cmd_op;
    logic [ARG_W-1:0]        cmd_arg;

    logic [VOL_W-1:0]        vol_l;
    logic [VOL_W-1:0]        vol_r;
    logic signed [ARG_W-1:0] snd_level;
    logic [VOL_W-1:0]        nxt_vol_l;
    logic [VOL_W-1:0]        nxt_vol_r;
    logic signed [ARG_W-1:0] nxt_level;

    // Signed level times unsigned volume fits in one sample
    function automatic snd_sample_t mix(
        input logic signed [ARG_W-1:0] lvl,
        input logic [VOL_W-1:0]        vol
    );
        logic signed [ARG_W+VOL_W:0] prod;
        prod = lvl * $signed({1'b0, vol});
        return prod[SAMPLE_W-1:0];
    endfunction

    // Sample rate divider restarting at reset release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

    // One command per tick and only while running
    assign pop = tick & run & ~empty;

    assign cmd_op  = snd_op_e'(pop_data[CMD_W-1:ARG_W]);
    assign cmd_arg = pop_data[ARG_W-1:0];

    // Command decoder feeding this tick's sample
    always_comb begin
        nxt_vol_l = vol_l;
        nxt_vol_r = vol_r;
        nxt_level = snd_level;
        if (pop) begin
            case (cmd_op)
                OP_VOL_L: nxt_vol_l = cmd_arg[VOL_W-1:0];
                OP_VOL_R: nxt_vol_r = cmd_arg[VOL_W-1:0];
                OP_PLAY:  nxt_level = $signed(cmd_arg);
                OP_MUTE: begin
                    nxt_vol_l = '0;
                    nxt_vol_r = '0;
                end
                // NOP and unknown codes leave the state alone
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vol_l     <= '0;
            vol_r     <= '0;
            snd_level <= '0;
            snd_left  <= '0;
            snd_right <= '0;
            sample    <= 1'b0;
        end else begin
            sample <= tick;
            if (tick) begin
                vol_l     <= nxt_vol_l;
                vol_r     <= nxt_vol_r;
                snd_level <= nxt_level;
                snd_left  <= mix(nxt_level, nxt_vol_l);
                snd_right <= mix(nxt_level, nxt_vol_r);
            end
        end
    end

    // Strobe lasts a single cycle
    a_sample_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) sample |=> !sample
    ) else $error("sample strobe held for more than one cycle");

    // Pops only happen on a tick so a strobe always follows
    a_pop_on_tick: assert property (
        @(posedge clk) disable iff (!rst_n) pop |=> sample
    ) else $error("command popped outside a sample tick");

endmodule

/* hw/cps15_cmd_fifo.sv */
`timescale 1ns/1ps

module cps15_cmd_fifo #(
    parameter int FIFO_DEPTH = 8,
    parameter int CMD_W      = cps15_snd_pkg::CMD_W
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Write side
    input  logic                        push,
    input  logic [CMD_W-1:0]            push_data,
    // Read side
    input  logic                        pop,
    output logic [CMD_W-1:0]            pop_data,
    // Occupancy
    output logic [$clog2(FIFO_DEPTH):0] level,
    output logic                        full,
    output logic                        empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [CMD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is always visible
    assign pop_data = mem[rd_ptr];
    assign level    = count;
    assign full     = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign empty    = (count == '0);

    // The bridge must refuse writes while full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !full
    ) else $error("push while command FIFO is full");

    // The sequencer must hold off while empty
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> !empty
    ) else $error("pop while command FIFO is empty");

endmodule

/* hw/cps15_main_if.sv */
`timescale 1ns/1ps

module cps15_main_if #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // APB slave
    input  logic [cps15_snd_pkg::APB_AW-1:0]  paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [cps15_snd_pkg::APB_DW-1:0]  pwdata,
    output logic [cps15_snd_pkg::APB_DW-1:0]  prdata,
    output logic                              pready,
    output logic                              pslverr,
    // Command FIFO side
    input  logic [$clog2(FIFO_DEPTH):0]       level,
    input  logic                              full,
    input  logic                              empty,
    output logic                              push,
    output logic [cps15_snd_pkg::CMD_W-1:0]   push_data,
    // Sequencer control
    output logic                              run
);

    import cps15_snd_pkg::*;

    logic       access;
    logic       hit_cmd;
    logic       hit_ctrl;
    logic       hit_status;
    logic       mapped;
    logic       bad_write;
    logic [7:0] level_byte;

    // Zero wait states, every access cycle completes
    assign access = psel & penable;
    assign pready = access;

    assign hit_cmd    = (paddr == REG_CMD);
    assign hit_ctrl   = (paddr == REG_CTRL);
    assign hit_status = (paddr == REG_STATUS);
    assign mapped     = hit_cmd | hit_ctrl | hit_status;

    // STATUS is read only, CMD refuses writes once the FIFO is full
    assign bad_write = pwrite & (hit_status | (hit_cmd & full));
    assign pslverr   = access & (~mapped | bad_write);

    assign push      = access & pwrite & hit_cmd & ~full;
    assign push_data = pwdata[CMD_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (access && pwrite && hit_ctrl) begin
            run <= pwdata[0];
        end
    end

    assign level_byte = 8'(level);

    // Read mux, CMD reads back as zero
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_CTRL: begin
                    prdata = {{(APB_DW-1){1'b0}}, run};
                end
                REG_STATUS: begin
                    prdata[7:0]              = level_byte;
                    prdata[STATUS_EMPTY_BIT] = empty;
                    prdata[STATUS_FULL_BIT]  = full;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

    // Access phase must follow a setup phase on the same select
    a_penable_after_setup: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel && $past(psel)
    ) else $error("penable rose without a preceding APB setup cycle");

endmodule

/* hw/cps15_snd_pkg.sv */
package cps15_snd_pkg;

    // Command word layout: opcode on top, argument below
    localparam int CMD_W    = 16;
    localparam int ARG_W    = 12;
    localparam int OP_W     = CMD_W - ARG_W;
    localparam int VOL_W    = 4;
    localparam int SAMPLE_W = 16;

    // APB port sizes
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    // Register map
    localparam logic [APB_AW-1:0] REG_CMD    = 4'h0;
    localparam logic [APB_AW-1:0] REG_CTRL   = 4'h4;
    localparam logic [APB_AW-1:0] REG_STATUS = 4'h8;

    // STATUS fields
    localparam int STATUS_EMPTY_BIT = 8;
    localparam int STATUS_FULL_BIT  = 9;

    // Sound command opcodes
    typedef enum logic [OP_W-1:0] {
        OP_NOP   = 4'h0,
        OP_VOL_L = 4'h1,
        OP_VOL_R = 4'h2,
        OP_PLAY  = 4'h3,
        OP_MUTE  = 4'h4
    } snd_op_e;

    typedef logic signed [SAMPLE_W-1:0] snd_sample_t;

endpackage
